//--- hw/fixed_point_pkg.sv
package fixed_point_pkg;

   // signed Q8.8 word, used for vertex coordinates and matrix coefficients
   typedef logic signed [15:0] coord_t;

   // full product of two coordinates, 16 fraction bits
   typedef logic signed [31:0] prod_t;

   // sum of four products
   // two guard bits so the worst case of four full-scale products cannot wrap
   typedef logic signed [33:0] acc_t;

   // clamp limits after the final shift
   localparam coord_t coord_max = 16'sh7fff;
   localparam coord_t coord_min = 16'sh8000;

endpackage

//--- hw/geometry_pkg.sv
package geometry_pkg;

   // shape of one transform
   localparam int vec_len  = 4;   // x, y, z, w
   localparam int mat_len  = 16;  // 4x4 entries, row by row
   localparam int load_len = 20;  // vertex words followed by matrix words

   // position in the load stream where matrix words start
   localparam int matrix_base = 4;

   // counts words of the current load
   typedef logic [4:0] word_idx_t;

   // vertex component, also used as row number of the result
   typedef logic [1:0] vec_idx_t;

   // matrix entry, row in [3:2] and column in [1:0]
   typedef logic [3:0] mat_idx_t;

endpackage

//--- hw/stream_loader.sv
`timescale 1ns/1ps

module stream_loader (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    input_valid,
   input  fixed_point_pkg::coord_t data_in,
   input  logic                    compute_done,
   output logic                    vec_we,
   output geometry_pkg::vec_idx_t  vec_waddr,
   output logic                    mat_we,
   output geometry_pkg::mat_idx_t  mat_waddr,
   output fixed_point_pkg::coord_t wr_data,
   output logic                    load_done,
   output logic                    busy
);

   typedef enum logic [1:0] {
      ph_idle,
      ph_loading,
      ph_waiting
   } phase_t;

   localparam geometry_pkg::word_idx_t matrix_start =
      geometry_pkg::word_idx_t'(geometry_pkg::matrix_base);
   localparam geometry_pkg::word_idx_t last_idx =
      geometry_pkg::word_idx_t'(geometry_pkg::load_len - 1);

   phase_t                  phase;
   geometry_pkg::word_idx_t word_cnt;   // words taken so far in this load
   geometry_pkg::word_idx_t mat_offset;
   logic                    in_wait;
   logic                    accept;
   logic                    last_word;

   // the done pulse already releases the wait, so a word can follow it directly
   assign in_wait   = (phase == ph_waiting) && !compute_done;
   assign accept    = input_valid && !in_wait;
   assign last_word = (word_cnt == last_idx);
   assign busy      = (phase == ph_loading) || in_wait;

   // routing by position in the stream
   assign mat_offset = word_cnt - matrix_start;
   assign vec_we     = accept && (word_cnt < matrix_start);
   assign mat_we     = accept && (word_cnt >= matrix_start);
   assign vec_waddr  = geometry_pkg::vec_idx_t'(word_cnt);
   assign mat_waddr  = geometry_pkg::mat_idx_t'(mat_offset);
   assign wr_data    = data_in;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         phase     <= ph_idle;
         word_cnt  <= '0;   // partial load is dropped
         load_done <= 1'b0;
      end else begin
         load_done <= accept && last_word;
         if (accept) begin
            if (last_word) begin
               word_cnt <= '0;
               phase    <= ph_waiting;   // hold off until the engine is done
            end else begin
               word_cnt <= word_cnt + 1'b1;
               phase    <= ph_loading;
            end
         end else if ((phase == ph_waiting) && compute_done) begin
            phase <= ph_idle;
         end
      end
   end

endmodule

//--- hw/word_store.sv
`timescale 1ns/1ps

module word_store #(
   parameter int depth = 16
) (
   input  logic                       clk,
   input  logic                       we,
   input  logic [$clog2(depth)-1:0]   waddr,
   input  fixed_point_pkg::coord_t    wdata,
   input  logic [$clog2(depth)-1:0]   raddr,
   output fixed_point_pkg::coord_t    rdata
);

   fixed_point_pkg::coord_t mem [depth];

   // write and read ports are independent
   always_ff @(posedge clk) begin
      if (we) begin
         mem[waddr] <= wdata;
      end
      rdata <= mem[raddr];   // one cycle read latency
   end

endmodule

//--- hw/transform_engine.sv
`timescale 1ns/1ps

module transform_engine #(
   parameter int frac_bits = 8
) (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    start,
   input  fixed_point_pkg::coord_t vec_rdata,
   input  fixed_point_pkg::coord_t mat_rdata,
   output geometry_pkg::vec_idx_t  vec_raddr,
   output geometry_pkg::mat_idx_t  mat_raddr,
   output fixed_point_pkg::coord_t result_x,
   output fixed_point_pkg::coord_t result_y,
   output fixed_point_pkg::coord_t result_z,
   output fixed_point_pkg::coord_t result_w,
   output logic                    compute_done
);

   // read side
   geometry_pkg::mat_idx_t  rd_cnt;     // entry being addressed, rests at 0
   logic                    running;
   logic                    issue;

   // tag that follows the read data into the accumulator
   logic                    rd_valid;
   geometry_pkg::mat_idx_t  rd_idx;

   // accumulate side
   fixed_point_pkg::prod_t  prod;
   fixed_point_pkg::acc_t   acc;
   fixed_point_pkg::acc_t   shifted;
   fixed_point_pkg::coord_t sat_val;
   geometry_pkg::vec_idx_t  row_sel;    // row held in acc
   logic                    row_end;    // acc holds a finished row
   fixed_point_pkg::coord_t row_res [geometry_pkg::vec_len];
   logic                    fin;        // last row is in row_res

   assign issue     = start || running;
   assign mat_raddr = rd_cnt;
   assign vec_raddr = geometry_pkg::vec_idx_t'(rd_cnt);   // column picks the vertex word

   assign prod    = vec_rdata * mat_rdata;   // signed, 16 fraction bits
   assign shifted = acc >>> frac_bits;       // floor toward minus infinity

   always_comb begin
      if (shifted > fixed_point_pkg::acc_t'(fixed_point_pkg::coord_max)) begin
         sat_val = fixed_point_pkg::coord_max;
      end else if (shifted < fixed_point_pkg::acc_t'(fixed_point_pkg::coord_min)) begin
         sat_val = fixed_point_pkg::coord_min;
      end else begin
         sat_val = fixed_point_pkg::coord_t'(shifted);
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rd_cnt       <= '0;
         running      <= 1'b0;
         rd_valid     <= 1'b0;
         row_end      <= 1'b0;
         fin          <= 1'b0;
         compute_done <= 1'b0;
         result_x     <= '0;
         result_y     <= '0;
         result_z     <= '0;
         result_w     <= '0;
      end else begin
         rd_valid <= issue;
         if (issue) begin
            rd_cnt  <= rd_cnt + 1'b1;   // wraps back to 0 after entry 15
            running <= (rd_cnt != '1);
         end

         // fourth column closes a row
         row_end <= rd_valid && (rd_idx[1:0] == 2'd3);
         fin     <= row_end && (row_sel == 2'd3);

         compute_done <= fin;
         if (fin) begin
            result_x <= row_res[0];
            result_y <= row_res[1];
            result_z <= row_res[2];
            result_w <= row_res[3];
         end
      end
   end

   // datapath
   always_ff @(posedge clk) begin
      if (issue) begin
         rd_idx <= rd_cnt;
      end
      if (rd_valid) begin
         // first column restarts the sum
         if (rd_idx[1:0] == 2'd0) begin
            acc <= fixed_point_pkg::acc_t'(prod);
         end else begin
            acc <= acc + prod;
         end
         row_sel <= rd_idx[3:2];
      end
      // old row_sel still names the finished row here
      if (row_end) begin
         row_res[row_sel] <= sat_val;
      end
   end

endmodule

//--- hw/vertex_transform_top.sv
`timescale 1ns/1ps

module vertex_transform_top #(
   parameter int frac_bits = 8
) (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    input_valid,
   input  fixed_point_pkg::coord_t data_in,
   output logic                    busy,
   output logic                    compute_done,
   output fixed_point_pkg::coord_t result_x,
   output fixed_point_pkg::coord_t result_y,
   output fixed_point_pkg::coord_t result_z,
   output fixed_point_pkg::coord_t result_w
);

   // loader to stores
   logic                    vec_we;
   logic                    mat_we;
   geometry_pkg::vec_idx_t  vec_waddr;
   geometry_pkg::mat_idx_t  mat_waddr;
   fixed_point_pkg::coord_t wr_data;

   // engine to stores and back
   geometry_pkg::vec_idx_t  vec_raddr;
   geometry_pkg::mat_idx_t  mat_raddr;
   fixed_point_pkg::coord_t vec_rdata;
   fixed_point_pkg::coord_t mat_rdata;

   logic                    load_done;

   stream_loader u_loader (
      .clk          (clk),
      .rst          (rst),
      .input_valid  (input_valid),
      .data_in      (data_in),
      .compute_done (compute_done),
      .vec_we       (vec_we),
      .vec_waddr    (vec_waddr),
      .mat_we       (mat_we),
      .mat_waddr    (mat_waddr),
      .wr_data      (wr_data),
      .load_done    (load_done),
      .busy         (busy)
   );

   word_store #(
      .depth (geometry_pkg::vec_len)
   ) u_vec_store (
      .clk   (clk),
      .we    (vec_we),
      .waddr (vec_waddr),
      .wdata (wr_data),
      .raddr (vec_raddr),
      .rdata (vec_rdata)
   );

   word_store #(
      .depth (geometry_pkg::mat_len)
   ) u_mat_store (
      .clk   (clk),
      .we    (mat_we),
      .waddr (mat_waddr),
      .wdata (wr_data),
      .raddr (mat_raddr),
      .rdata (mat_rdata)
   );

   transform_engine #(
      .frac_bits (frac_bits)
   ) u_engine (
      .clk          (clk),
      .rst          (rst),
      .start        (load_done),
      .vec_rdata    (vec_rdata),
      .mat_rdata    (mat_rdata),
      .vec_raddr    (vec_raddr),
      .mat_raddr    (mat_raddr),
      .result_x     (result_x),
      .result_y     (result_y),
      .result_z     (result_z),
      .result_w     (result_w),
      .compute_done (compute_done)
   );

endmodule

//--- tb/vertex_transform_tb.sv
`timescale 1ns/1ps

module vertex_transform_tb;

   logic                    clk;
   logic                    rst;
   logic                    input_valid;
   fixed_point_pkg::coord_t data_in;
   logic                    busy;
   logic                    compute_done;
   fixed_point_pkg::coord_t result_x;
   fixed_point_pkg::coord_t result_y;
   fixed_point_pkg::coord_t result_z;
   fixed_point_pkg::coord_t result_w;

   // words of the current load and the results they should give
   fixed_point_pkg::coord_t ref_vec [geometry_pkg::vec_len];
   fixed_point_pkg::coord_t ref_mat [geometry_pkg::mat_len];
   fixed_point_pkg::coord_t exp_res [geometry_pkg::vec_len];
   fixed_point_pkg::coord_t prev_res [geometry_pkg::vec_len];

   int   m_count;   // words taken in the load being modeled
   int   m_edges;   // edges since word 20 was taken
   logic m_wait;
   int   errors;
   int   checks;
   logic timed_out;
   int   i;
   int   k;

   vertex_transform_top #(
      .frac_bits (8)
   ) u_vertex_transform_top (
      .clk          (clk),
      .rst          (rst),
      .input_valid  (input_valid),
      .data_in      (data_in),
      .busy         (busy),
      .compute_done (compute_done),
      .result_x     (result_x),
      .result_y     (result_y),
      .result_z     (result_z),
      .result_w     (result_w)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic check_value(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
      checks++;
      assert (actual === expected) else begin
         errors++;
         $display("[ERROR] %s expected %h actual %h at %0t", name, expected, actual, $time);
      end
   endtask

   task automatic check_results(input logic [15:0] ex, input logic [15:0] ey,
                                input logic [15:0] ez, input logic [15:0] ew);
      check_value("result_x", ex, result_x);
      check_value("result_y", ey, result_y);
      check_value("result_z", ez, result_z);
      check_value("result_w", ew, result_w);
   endtask

   // row dot product, floor shift by 8, clamp to 16 bits
   function automatic fixed_point_pkg::coord_t ref_result(input int row);
      longint sum;
      longint scaled;
      int     col;
      sum = 0;
      for (col = 0; col < 4; col++) begin
         sum = sum + longint'(ref_mat[row * 4 + col]) * longint'(ref_vec[col]);
      end
      scaled = sum >>> 8;
      if (scaled > 32767) begin
         ref_result = fixed_point_pkg::coord_max;
      end else if (scaled < -32768) begin
         ref_result = fixed_point_pkg::coord_min;
      end else begin
         ref_result = fixed_point_pkg::coord_t'(scaled);
      end
   endfunction

   function automatic fixed_point_pkg::coord_t rand_coord(input logic full_range);
      int r;
      if (full_range) begin
         r = $urandom_range(0, 65535) - 32768;
      end else begin
         r = $urandom_range(0, 2047) - 1024;   // within +-4.0
      end
      rand_coord = fixed_point_pkg::coord_t'(r);
   endfunction

   task automatic fill_random(input logic full_range);
      int idx;
      for (idx = 0; idx < geometry_pkg::vec_len; idx++) begin
         ref_vec[idx] = rand_coord(full_range);
      end
      for (idx = 0; idx < geometry_pkg::mat_len; idx++) begin
         ref_mat[idx] = rand_coord(full_range);
      end
   endtask

   task automatic fill_uniform(input fixed_point_pkg::coord_t v,
                               input fixed_point_pkg::coord_t m);
      int idx;
      for (idx = 0; idx < geometry_pkg::vec_len; idx++) begin
         ref_vec[idx] = v;
      end
      for (idx = 0; idx < geometry_pkg::mat_len; idx++) begin
         ref_mat[idx] = m;
      end
   endtask

   // one to three cycles per word
   task automatic send_word(input fixed_point_pkg::coord_t w);
      int gap;
      gap = $urandom_range(0, 2);
      repeat (gap) begin
         @(posedge clk);
         input_valid <= 1'b0;
      end
      @(posedge clk);
      input_valid <= 1'b1;
      data_in     <= w;
   endtask

   task automatic wait_done();
      int n;
      n = 0;
      while (!compute_done && n < 100) begin
         @(posedge clk);
         n++;
      end
      if (!compute_done) begin
         timed_out = 1'b1;
         $display("compute_done never arrived");
      end
   endtask

   task automatic send_load(input logic with_junk);
      int idx;
      int n_junk;
      for (idx = 0; idx < geometry_pkg::vec_len; idx++) begin
         send_word(ref_vec[idx]);
      end
      for (idx = 0; idx < geometry_pkg::mat_len; idx++) begin
         send_word(ref_mat[idx]);
      end
      n_junk = with_junk ? $urandom_range(4, 12) : 0;
      repeat (n_junk) begin   // lands in the wait phase
         @(posedge clk);
         input_valid <= 1'b1;
         data_in     <= fixed_point_pkg::coord_t'($urandom);
      end
      @(posedge clk);
      input_valid <= 1'b0;
      for (idx = 0; idx < geometry_pkg::vec_len; idx++) begin
         exp_res[idx] = ref_result(idx);
      end
      wait_done();
   endtask

   // sees the values of the cycle that ends at this edge
   always @(posedge clk) begin : protocol_check
      logic exp_done;
      logic exp_busy;
      logic accepted;
      if (rst) begin
         check_value("busy", 16'h0, {15'd0, busy});
         check_value("compute_done", 16'h0, {15'd0, compute_done});
         check_results(16'h0, 16'h0, 16'h0, 16'h0);
         m_count = 0;
         m_edges = 0;
         m_wait  = 1'b0;
         prev_res = '{default: '0};
      end else begin
         exp_done = m_wait && (m_edges == 19);
         exp_busy = (m_count != 0) || (m_wait && !exp_done);
         check_value("compute_done", {15'd0, exp_done}, {15'd0, compute_done});
         check_value("busy", {15'd0, exp_busy}, {15'd0, busy});
         if (compute_done) begin
            check_results(exp_res[0], exp_res[1], exp_res[2], exp_res[3]);
         end else begin
            check_results(prev_res[0], prev_res[1], prev_res[2], prev_res[3]);
         end
         prev_res[0] = result_x;
         prev_res[1] = result_y;
         prev_res[2] = result_z;
         prev_res[3] = result_w;
         accepted = input_valid && !(m_wait && !exp_done);
         if (m_wait) begin
            m_edges++;
         end
         if (exp_done) begin
            m_wait = 1'b0;
         end
         if (accepted && m_count == geometry_pkg::load_len - 1) begin
            m_count = 0;
            m_wait  = 1'b1;
            m_edges = 0;
         end else if (accepted) begin
            m_count++;
         end
      end
   end

   initial begin
      errors      = 0;
      checks      = 0;
      timed_out   = 1'b0;
      void'($urandom(32'hd00b));
      rst         = 1'b1;
      input_valid = 1'b0;
      data_in     = '0;
      repeat (8) @(posedge clk);
      rst <= 1'b0;
      repeat (3) @(posedge clk);
      check_value("busy", 16'h0, {15'd0, busy});
      check_value("compute_done", 16'h0, {15'd0, compute_done});
      check_results(16'h0, 16'h0, 16'h0, 16'h0);

      for (k = 0; k < 2 && !timed_out; k++) begin
         fill_random(1'b1);
         for (i = 0; i < geometry_pkg::mat_len; i++) begin
            ref_mat[i] = (i % 5 == 0) ? 16'sh0100 : 16'sh0000;   // 1.0 on the diagonal
         end
         send_load(1'b0);
         if (!timed_out) begin
            check_results(ref_vec[0], ref_vec[1], ref_vec[2], ref_vec[3]);
         end
      end

      for (k = 0; k < 30 && !timed_out; k++) begin
         fill_random(1'b0);
         send_load(1'b0);
      end

      fill_uniform(16'sh7fff, 16'sh7fff);
      if (!timed_out) begin
         send_load(1'b0);
      end
      if (!timed_out) begin
         check_results(16'h7fff, 16'h7fff, 16'h7fff, 16'h7fff);
      end
      fill_uniform(16'sh7fff, 16'sh8000);
      if (!timed_out) begin
         send_load(1'b0);
      end
      if (!timed_out) begin
         check_results(16'h8000, 16'h8000, 16'h8000, 16'h8000);
      end
      for (k = 0; k < 5 && !timed_out; k++) begin
         fill_random(1'b1);
         send_load(1'b0);
      end

      // junk during the wait, then a clean load afterwards
      for (k = 0; k < 6 && !timed_out; k++) begin
         fill_random(1'b0);
         send_load(k < 5);
         repeat (3) @(posedge clk);
         check_value("busy", 16'h0, {15'd0, busy});
      end

      repeat (4) @(posedge clk);
      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0 && !timed_out) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

//--- vertex_transform_top.f
hw/fixed_point_pkg.sv
hw/geometry_pkg.sv
hw/stream_loader.sv
hw/word_store.sv
hw/transform_engine.sv
hw/vertex_transform_top.sv
tb/vertex_transform_tb.sv
